//--- common/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int WORD_W  = 32;
    localparam int TAG_W   = 20;
    localparam int INDEX_W = 7;
    localparam int BANK_W  = 3;
    localparam int BYTE_W  = 2;
    localparam int SET_NUM = 128;
    localparam int LINE_W  = 256;
    localparam int TAGV_W  = 21;

    // cache-op modes, all three invalidate the whole set
    localparam logic [1:0] CACOP_IDX_INV0 = 2'd0;
    localparam logic [1:0] CACOP_IDX_INV1 = 2'd1;
    localparam logic [1:0] CACOP_HIT_INV  = 2'd2;

    // decode FSM
    localparam logic [1:0] DEC_SWEEP = 2'd0;
    localparam logic [1:0] DEC_IDLE  = 2'd1;
    localparam logic [1:0] DEC_BUSY  = 2'd2;
    localparam logic [1:0] DEC_ACK   = 2'd3;

    // lookup FSM
    localparam logic [1:0] LK_IDLE = 2'd0;
    localparam logic [1:0] LK_CMP  = 2'd1;
    localparam logic [1:0] LK_WAIT = 2'd2;

    // address split, msb first
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [BANK_W-1:0]  bank;
        logic [BYTE_W-1:0]  byte_off;
    } icache_addr_fields_t;

    // same word seen as bus address or as cache fields
    typedef union packed {
        logic [WORD_W-1:0]   raw;
        icache_addr_fields_t fields;
    } icache_addr_u;

endpackage

//--- rtl/sdp_ram.sv
`timescale 1ns/100ps

module sdp_ram
    import icache_pkg::*;
#(
    parameter int WIDTH = TAGV_W
) (
    input  logic               clk,
    input  logic               we_i,
    input  logic [INDEX_W-1:0] waddr_i,
    input  logic [WIDTH-1:0]   wdata_i,
    input  logic [INDEX_W-1:0] raddr_i,
    output logic [WIDTH-1:0]   rdata_o
);

    logic [WIDTH-1:0] mem [SET_NUM];

    // read returns old data on a same-address write
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];
    end

endmodule

//--- icache/icache_decode.sv
`timescale 1ns/100ps

module icache_decode
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_req_i,
    input  logic [WORD_W-1:0] fetch_pc_i,
    input  logic              fetch_uncached_i,
    output logic              fetch_ack_o,
    input  logic              cacop_req_i,
    input  logic [1:0]        cacop_mode_i,
    input  logic [WORD_W-1:0] cacop_addr_i,
    output logic              cacop_ack_o,
    input  logic              res_done_i,
    output logic              op_start_o,
    output icache_addr_u      op_addr_o,
    output logic              op_fetch_o,
    output logic              op_uncached_o,
    output logic              op_inval_o
);

    logic [1:0]         state_q;
    logic [INDEX_W-1:0] sweep_cnt_q;
    logic               is_cacop_q;
    logic               cacop_inval;
    logic               req_held;

    // mode 3 is a no-op
    assign cacop_inval = cacop_mode_i inside {CACOP_IDX_INV0, CACOP_IDX_INV1, CACOP_HIT_INV};
    assign req_held    = is_cacop_q ? cacop_req_i : fetch_req_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= DEC_SWEEP;
            sweep_cnt_q <= '0;
            is_cacop_q  <= 1'b0;
            op_start_o  <= 1'b0;
            op_inval_o  <= 1'b0;
            fetch_ack_o <= 1'b0;
            cacop_ack_o <= 1'b0;
        end else begin
            op_start_o <= 1'b0;
            op_inval_o <= 1'b0;
            case (state_q)
                DEC_SWEEP: begin
                    // clear one set of valid bits per cycle
                    op_inval_o  <= 1'b1;
                    sweep_cnt_q <= sweep_cnt_q + 1'b1;
                    if (sweep_cnt_q == INDEX_W'(SET_NUM - 1)) begin
                        state_q <= DEC_IDLE;
                    end
                end
                DEC_IDLE: begin
                    // cache op wins over fetch
                    if (cacop_req_i) begin
                        op_start_o <= 1'b1;
                        op_inval_o <= cacop_inval;
                        is_cacop_q <= 1'b1;
                        state_q    <= DEC_BUSY;
                    end else if (fetch_req_i) begin
                        op_start_o <= 1'b1;
                        is_cacop_q <= 1'b0;
                        state_q    <= DEC_BUSY;
                    end
                end
                DEC_BUSY: begin
                    if (res_done_i) begin
                        if (is_cacop_q) begin
                            cacop_ack_o <= 1'b1;
                        end else begin
                            fetch_ack_o <= 1'b1;
                        end
                        state_q <= DEC_ACK;
                    end
                end
                DEC_ACK: begin
                    if (!req_held) begin
                        fetch_ack_o <= 1'b0;
                        cacop_ack_o <= 1'b0;
                        state_q     <= DEC_IDLE;
                    end
                end
                default: state_q <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            DEC_SWEEP: begin
                op_addr_o.raw          <= '0;
                op_addr_o.fields.index <= sweep_cnt_q;
            end
            DEC_IDLE: begin
                if (cacop_req_i) begin
                    op_addr_o.raw <= cacop_addr_i;
                    op_fetch_o    <= 1'b0;
                    op_uncached_o <= 1'b0;
                end else if (fetch_req_i) begin
                    op_addr_o.raw <= fetch_pc_i;
                    op_fetch_o    <= 1'b1;
                    op_uncached_o <= fetch_uncached_i;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- icache/icache_lookup.sv
`timescale 1ns/100ps

module icache_lookup
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              op_start_i,
    input  icache_addr_u      op_addr_i,
    input  logic              op_fetch_i,
    input  logic              op_uncached_i,
    input  logic              op_inval_i,
    output logic              refill_start_o,
    output icache_addr_u      refill_addr_o,
    output logic              refill_uncached_o,
    input  logic              refill_done_i,
    input  logic [LINE_W-1:0] refill_line_i,
    output logic              lookup_done_o,
    output logic [LINE_W-1:0] lookup_line_o,
    output icache_addr_u      lookup_addr_o
);

    logic [1:0]         state_q;
    icache_addr_u       addr_q;
    logic               uncached_q;
    logic [SET_NUM-1:0] lru_q;

    logic [TAGV_W-1:0]  tagv_rd [2];
    logic [LINE_W-1:0]  data_rd [2];
    logic [1:0]         way_hit;
    logic               victim;
    logic               inval_we;
    logic               fill_we;
    logic [INDEX_W-1:0] tag_waddr;
    logic [TAGV_W-1:0]  tag_wdata;

    // lru bit names the way to replace next
    assign victim    = lru_q[addr_q.fields.index];
    assign inval_we  = (state_q == LK_IDLE) && op_inval_i;
    assign fill_we   = (state_q == LK_WAIT) && refill_done_i && !uncached_q;
    assign tag_waddr = inval_we ? op_addr_i.fields.index : addr_q.fields.index;
    assign tag_wdata = inval_we ? '0 : {1'b1, addr_q.fields.tag};

    for (genvar w = 0; w < 2; w++) begin : g_way
        // uncached fetches never hit
        assign way_hit[w] = tagv_rd[w][TAGV_W-1] && !uncached_q &&
                            (tagv_rd[w][TAG_W-1:0] == addr_q.fields.tag);

        sdp_ram #(.WIDTH(TAGV_W)) u_tagv (
            .clk     (clk),
            .we_i    (inval_we || (fill_we && (victim == 1'(w)))),
            .waddr_i (tag_waddr),
            .wdata_i (tag_wdata),
            .raddr_i (op_addr_i.fields.index),
            .rdata_o (tagv_rd[w])
        );

        sdp_ram #(.WIDTH(LINE_W)) u_data (
            .clk     (clk),
            .we_i    (fill_we && (victim == 1'(w))),
            .waddr_i (addr_q.fields.index),
            .wdata_i (refill_line_i),
            .raddr_i (op_addr_i.fields.index),
            .rdata_o (data_rd[w])
        );
    end

    assign refill_start_o    = (state_q == LK_CMP) && (way_hit == 2'b00);
    assign refill_addr_o     = addr_q;
    assign refill_uncached_o = uncached_q;
    assign lookup_addr_o     = addr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q       <= LK_IDLE;
            lookup_done_o <= 1'b0;
            lru_q         <= '0;
        end else begin
            lookup_done_o <= 1'b0;
            case (state_q)
                LK_IDLE: begin
                    if (op_start_i) begin
                        // cache ops finish here, the write happens this cycle
                        if (op_fetch_i) begin
                            state_q <= LK_CMP;
                        end else begin
                            lookup_done_o <= 1'b1;
                        end
                    end
                end
                LK_CMP: begin
                    if (|way_hit) begin
                        lookup_done_o                 <= 1'b1;
                        lru_q[addr_q.fields.index]    <= way_hit[0];
                        state_q                       <= LK_IDLE;
                    end else begin
                        state_q <= LK_WAIT;
                    end
                end
                LK_WAIT: begin
                    if (refill_done_i) begin
                        lookup_done_o <= 1'b1;
                        if (!uncached_q) begin
                            lru_q[addr_q.fields.index] <= ~victim;
                        end
                        state_q <= LK_IDLE;
                    end
                end
                default: state_q <= LK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == LK_IDLE) && op_start_i) begin
            addr_q     <= op_addr_i;
            uncached_q <= op_uncached_i;
        end
        if ((state_q == LK_CMP) && (|way_hit)) begin
            lookup_line_o <= way_hit[0] ? data_rd[0] : data_rd[1];
        end else if ((state_q == LK_WAIT) && refill_done_i) begin
            lookup_line_o <= refill_line_i;
        end
    end

endmodule

//--- icache/icache_refill.sv
`timescale 1ns/100ps

module icache_refill
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              refill_start_i,
    input  icache_addr_u      refill_addr_i,
    input  logic              refill_uncached_i,
    output logic              mem_req_o,
    output logic [WORD_W-1:0] mem_addr_o,
    input  logic              mem_ack_i,
    input  logic [LINE_W-1:0] mem_rdata_i,
    output logic              refill_done_o,
    output logic [LINE_W-1:0] refill_line_o
);

    icache_addr_u req_addr;
    icache_addr_u pend_addr_q;
    logic         pend_q;
    logic         launch;
    logic         capture;

    // line refills start at bank 0, uncached reads keep the word
    always_comb begin
        req_addr                 = refill_addr_i;
        req_addr.fields.byte_off = '0;
        if (!refill_uncached_i) begin
            req_addr.fields.bank = '0;
        end
    end

    // a new request waits for the previous ack to drop
    assign launch  = !mem_req_o && (refill_start_i || pend_q) && !mem_ack_i;
    assign capture = mem_req_o && mem_ack_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_req_o     <= 1'b0;
            refill_done_o <= 1'b0;
            pend_q        <= 1'b0;
        end else begin
            refill_done_o <= capture;
            if (capture) begin
                mem_req_o <= 1'b0;
            end else if (launch) begin
                mem_req_o <= 1'b1;
                pend_q    <= 1'b0;
            end else if (refill_start_i) begin
                pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_start_i) begin
            pend_addr_q <= req_addr;
        end
        if (launch) begin
            mem_addr_o <= refill_start_i ? req_addr.raw : pend_addr_q.raw;
        end
        if (capture) begin
            refill_line_o <= mem_rdata_i;
        end
    end

endmodule

//--- icache/icache_result.sv
`timescale 1ns/100ps

module icache_result
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              lookup_done_i,
    input  logic [LINE_W-1:0] lookup_line_i,
    input  icache_addr_u      lookup_addr_i,
    output logic [WORD_W-1:0] fetch_inst_o,
    output logic              res_done_o
);

    logic [WORD_W-1:0] word_sel;

    // bank field picks one 32-bit lane of the line
    assign word_sel = lookup_line_i[lookup_addr_i.fields.bank * WORD_W +: WORD_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            res_done_o <= 1'b0;
        end else begin
            res_done_o <= lookup_done_i;
        end
    end

    // held until the next completion
    always_ff @(posedge clk) begin
        if (lookup_done_i) begin
            fetch_inst_o <= word_sel;
        end
    end

endmodule

//--- rtl/icache_top.sv
`timescale 1ns/100ps

module icache_top
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_req_i,
    input  logic [WORD_W-1:0] fetch_pc_i,
    input  logic              fetch_uncached_i,
    output logic              fetch_ack_o,
    output logic [WORD_W-1:0] fetch_inst_o,
    input  logic              cacop_req_i,
    input  logic [1:0]        cacop_mode_i,
    input  logic [WORD_W-1:0] cacop_addr_i,
    output logic              cacop_ack_o,
    output logic              mem_req_o,
    output logic [WORD_W-1:0] mem_addr_o,
    input  logic              mem_ack_i,
    input  logic [LINE_W-1:0] mem_rdata_i
);

    logic              op_start;
    icache_addr_u      op_addr;
    logic              op_fetch;
    logic              op_uncached;
    logic              op_inval;
    logic              refill_start;
    icache_addr_u      refill_addr;
    logic              refill_uncached;
    logic              refill_done;
    logic [LINE_W-1:0] refill_line;
    logic              lookup_done;
    logic [LINE_W-1:0] lookup_line;
    icache_addr_u      lookup_addr;
    logic              res_done;

    icache_decode u_decode (
        .clk              (clk),
        .reset            (reset),
        .fetch_req_i      (fetch_req_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_uncached_i (fetch_uncached_i),
        .fetch_ack_o      (fetch_ack_o),
        .cacop_req_i      (cacop_req_i),
        .cacop_mode_i     (cacop_mode_i),
        .cacop_addr_i     (cacop_addr_i),
        .cacop_ack_o      (cacop_ack_o),
        .res_done_i       (res_done),
        .op_start_o       (op_start),
        .op_addr_o        (op_addr),
        .op_fetch_o       (op_fetch),
        .op_uncached_o    (op_uncached),
        .op_inval_o       (op_inval)
    );

    icache_lookup u_lookup (
        .clk               (clk),
        .reset             (reset),
        .op_start_i        (op_start),
        .op_addr_i         (op_addr),
        .op_fetch_i        (op_fetch),
        .op_uncached_i     (op_uncached),
        .op_inval_i        (op_inval),
        .refill_start_o    (refill_start),
        .refill_addr_o     (refill_addr),
        .refill_uncached_o (refill_uncached),
        .refill_done_i     (refill_done),
        .refill_line_i     (refill_line),
        .lookup_done_o     (lookup_done),
        .lookup_line_o     (lookup_line),
        .lookup_addr_o     (lookup_addr)
    );

    icache_refill u_refill (
        .clk               (clk),
        .reset             (reset),
        .refill_start_i    (refill_start),
        .refill_addr_i     (refill_addr),
        .refill_uncached_i (refill_uncached),
        .mem_req_o         (mem_req_o),
        .mem_addr_o        (mem_addr_o),
        .mem_ack_i         (mem_ack_i),
        .mem_rdata_i       (mem_rdata_i),
        .refill_done_o     (refill_done),
        .refill_line_o     (refill_line)
    );

    icache_result u_result (
        .clk           (clk),
        .reset         (reset),
        .lookup_done_i (lookup_done),
        .lookup_line_i (lookup_line),
        .lookup_addr_i (lookup_addr),
        .fetch_inst_o  (fetch_inst_o),
        .res_done_o    (res_done)
    );

endmodule

//--- test/icache_asserts.sv
`timescale 1ns/100ps

module icache_asserts (
    input logic clk,
    input logic reset,
    input logic fetch_req_i,
    input logic fetch_ack_o,
    input logic cacop_req_i,
    input logic cacop_ack_o,
    input logic mem_req_o,
    input logic mem_ack_i
);

    // an ack only rises while its request is held
    fetch_ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(fetch_ack_o) |-> fetch_req_i)
        else $error("fetch_ack_o rose without fetch_req_i");

    cacop_ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(cacop_ack_o) |-> cacop_req_i)
        else $error("cacop_ack_o rose without cacop_req_i");

    // memory request held until memory answers
    mem_req_hold: assert property (@(posedge clk) disable iff (reset)
        (mem_req_o && !mem_ack_i) |=> mem_req_o)
        else $error("mem_req_o dropped before mem_ack_i");

    acks_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(fetch_ack_o && cacop_ack_o))
        else $error("fetch_ack_o and cacop_ack_o high together");

    acks_low_in_reset: assert property (@(posedge clk)
        reset |=> (!fetch_ack_o && !cacop_ack_o))
        else $error("ack high during reset");

endmodule

bind icache_top icache_asserts u_asserts (.*);

//--- test/icache_tb.sv
`timescale 1ns/100ps

module icache_tb
    import icache_pkg::*;
;

    localparam int VEC_MAX   = 64;
    localparam int WAIT_MAX  = 200;
    localparam int SWEEP_MAX = 400;

    logic              clk;
    logic              reset;
    logic              fetch_req_i;
    logic [WORD_W-1:0] fetch_pc_i;
    logic              fetch_uncached_i;
    logic              fetch_ack_o;
    logic [WORD_W-1:0] fetch_inst_o;
    logic              cacop_req_i;
    logic [1:0]        cacop_mode_i;
    logic [WORD_W-1:0] cacop_addr_i;
    logic              cacop_ack_o;
    logic              mem_req_o;
    logic [WORD_W-1:0] mem_addr_o;
    logic              mem_ack_i;
    logic [LINE_W-1:0] mem_rdata_i;

    logic [31:0] vec [0:VEC_MAX*5-1];

    // memory model state
    int          mem_state;
    int          mem_delay;
    int          mem_req_total;
    logic [31:0] mem_last_addr;

    int inst_errs;
    int mem_errs;
    int addr_errs;
    int timing_errs;
    int timeout_errs;

    icache_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // every word of memory holds its own address xor a fixed mask
    function automatic logic [LINE_W-1:0] line_for(input logic [31:0] addr);
        logic [LINE_W-1:0] line;
        logic [31:0]       base;
        base = addr & 32'hFFFF_FFE0;
        for (int i = 0; i < 8; i++) begin
            line[i*32 +: 32] = (base + (i << 2)) ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    // four-phase memory slave with a random ack delay
    always @(posedge clk) begin
        if (reset) begin
            mem_state <= 0;
            mem_ack_i <= 1'b0;
        end else begin
            case (mem_state)
                0: begin
                    if (mem_req_o && !mem_ack_i) begin
                        mem_delay     <= $urandom_range(6, 1);
                        mem_last_addr <= mem_addr_o;
                        mem_req_total <= mem_req_total + 1;
                        mem_state     <= 1;
                    end
                end
                1: begin
                    if (mem_delay <= 1) begin
                        mem_ack_i   <= 1'b1;
                        mem_rdata_i <= line_for(mem_last_addr);
                        mem_state   <= 2;
                    end else begin
                        mem_delay <= mem_delay - 1;
                    end
                end
                default: begin
                    if (!mem_req_o) begin
                        mem_ack_i <= 1'b0;
                        mem_state <= 0;
                    end
                end
            endcase
        end
    end

    task automatic check_inst(input logic [WORD_W-1:0] exp, input logic [WORD_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t fetch_inst_o expected %h got %h", $time, exp, act);
            inst_errs++;
        end
    endtask

    task automatic check_mem(input bit exp, input bit act);
        if (act !== exp) begin
            $display("FAIL t=%0t mem_req_o expected %0d got %0d", $time, exp, act);
            mem_errs++;
        end
    endtask

    task automatic check_addr(input icache_addr_u exp, input icache_addr_u act);
        if (act.raw !== exp.raw) begin
            $display("FAIL t=%0t mem_addr_o expected %h got %h", $time, exp.raw, act.raw);
            addr_errs++;
        end
    endtask

    // edges counts rising edges after the one where decode samples the request
    task automatic wait_ack(input bit is_cacop, output int edges, output bit ok);
        ok    = 1'b0;
        edges = -1;
        for (int n = 0; n < WAIT_MAX; n++) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (is_cacop ? cacop_ack_o : fetch_ack_o) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    // edges counts rising edges after the one that drives the request low
    task automatic wait_ack_low(input bit is_cacop, output int edges, output bit ok);
        ok    = 1'b0;
        edges = 0;
        for (int n = 0; n < WAIT_MAX; n++) begin
            @(negedge clk);
            if (!(is_cacop ? cacop_ack_o : fetch_ack_o)) begin
                ok = 1'b1;
                break;
            end
            edges++;
        end
    endtask

    initial begin
        int          idx;
        int          edges;
        int          req_before;
        int          req_count;
        bit          ok;
        bit          is_cacop;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] exp_inst;
        bit          exp_mem;
        icache_addr_u exp_addr;
        icache_addr_u got_addr;

        void'($urandom(77));
        inst_errs     = 0;
        mem_errs      = 0;
        addr_errs     = 0;
        timing_errs   = 0;
        timeout_errs  = 0;
        mem_req_total = 0;
        mem_last_addr = '0;
        mem_delay     = 0;
        mem_state     = 0;
        mem_rdata_i   = '0;

        reset            <= 1'b1;
        fetch_req_i      <= 1'b0;
        fetch_pc_i       <= '0;
        fetch_uncached_i <= 1'b0;
        cacop_req_i      <= 1'b0;
        cacop_mode_i     <= 2'd0;
        cacop_addr_i     <= '0;
        mem_ack_i        <= 1'b0;

        $readmemh("test/icache_vectors.txt", vec);

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // valid-bit sweep keeps decode busy
        ok = 1'b0;
        for (int n = 0; n < SWEEP_MAX; n++) begin
            @(negedge clk);
            if (DUT.u_decode.state_q == DEC_IDLE) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("timeout waiting for the reset sweep to finish");
            timeout_errs++;
        end

        idx = 0;
        while (ok && idx < VEC_MAX && vec[idx*5] !== 32'hF) begin
            op       = vec[idx*5];
            addr     = vec[idx*5 + 1];
            exp_inst = vec[idx*5 + 3];
            exp_mem  = vec[idx*5 + 4][0];
            is_cacop = (op == 32'h2);
            req_before = mem_req_total;

            @(posedge clk);
            if (is_cacop) begin
                cacop_addr_i <= addr;
                cacop_mode_i <= vec[idx*5 + 2][1:0];
                cacop_req_i  <= 1'b1;
            end else begin
                fetch_pc_i       <= addr;
                fetch_uncached_i <= (op == 32'h1);
                fetch_req_i      <= 1'b1;
            end

            wait_ack(is_cacop, edges, ok);
            if (!ok) begin
                $display("timeout waiting for the ack of vector %0d", idx);
                timeout_errs++;
                break;
            end

            if (is_cacop && edges != 3) begin
                $display("FAIL t=%0t cacop_ack_o latency expected 3 got %0d", $time, edges);
                timing_errs++;
            end
            if (op == 32'h0 && !exp_mem && edges != 4) begin
                $display("FAIL t=%0t fetch_ack_o latency expected 4 got %0d", $time, edges);
                timing_errs++;
            end
            if (!is_cacop) begin
                check_inst(exp_inst, fetch_inst_o);
            end

            @(posedge clk);
            fetch_req_i <= 1'b0;
            cacop_req_i <= 1'b0;
            wait_ack_low(is_cacop, edges, ok);
            if (!ok) begin
                $display("timeout waiting for the ack of vector %0d to drop", idx);
                timeout_errs++;
                break;
            end

            // the ack stays up until decode has seen the request low
            if (edges != 1) begin
                $display("FAIL t=%0t %s drop latency expected 1 got %0d", $time,
                         is_cacop ? "cacop_ack_o" : "fetch_ack_o", edges);
                timing_errs++;
            end

            req_count = mem_req_total - req_before;
            check_mem(exp_mem, req_count != 0);
            if (req_count > 1) begin
                $display("vector %0d issued %0d memory requests instead of one", idx, req_count);
                mem_errs++;
            end
            if (exp_mem && req_count != 0) begin
                exp_addr.raw = (op == 32'h1) ? (addr & 32'hFFFF_FFFC) : (addr & 32'hFFFF_FFE0);
                got_addr.raw = mem_last_addr;
                check_addr(exp_addr, got_addr);
            end

            repeat ($urandom_range(3, 0)) @(posedge clk);
            idx++;
        end

        $display("errors: inst %0d mem %0d addr %0d timing %0d timeout %0d",
                 inst_errs, mem_errs, addr_errs, timing_errs, timeout_errs);
        if (inst_errs + mem_errs + addr_errs + timing_errs + timeout_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- test/icache_vectors.txt
// columns: op (0 fetch, 1 uncached, 2 cacop, f end) addr mode exp_inst exp_mem
// exp_inst is addr xor a5a50000 for fetches, unused for cache ops
// first fetch to a line misses, then hits anywhere in the line
0 000010A4 0 A5A510A4 1
0 000010B8 0 A5A510B8 0
0 000010A0 0 A5A510A0 0
// two tags at index 3 fill both ways
0 00002064 0 A5A52064 1
0 00003068 0 A5A53068 1
0 0000207C 0 A5A5207C 0
0 00003060 0 A5A53060 0
// touch X then Z evicts Y
0 00002064 0 A5A52064 0
0 00004070 0 A5A54070 1
0 00002068 0 A5A52068 0
0 00003068 0 A5A53068 1
0 00002060 0 A5A52060 0
0 00003064 0 A5A53064 0
// uncached reads always go to memory and do not allocate
1 00005108 0 A5A55108 1
1 00005108 0 A5A55108 1
1 0000511C 0 A5A5511C 1
0 0000510C 0 A5A5510C 1
0 00005100 0 A5A55100 0
// mode 0 invalidates index 5
2 000010A0 0 00000000 0
0 000010A4 0 A5A510A4 1
0 000010AC 0 A5A510AC 0
// mode 3 leaves index 5 alone
2 000010A0 3 00000000 0
0 000010A8 0 A5A510A8 0
// mode 1 invalidates both ways of index 3
2 00000060 1 00000000 0
0 00002064 0 A5A52064 1
0 00003064 0 A5A53064 1
0 00002070 0 A5A52070 0
// mode 2 invalidates index 8
2 00005100 2 00000000 0
0 00005104 0 A5A55104 1
2 00005100 3 00000000 0
0 00005104 0 A5A55104 0
0 00005118 0 A5A55118 0
// uncached after a hit still reads memory
1 00005110 0 A5A55110 1
0 00005114 0 A5A55114 0
f 00000000 0 00000000 0

//--- icache.f
common/icache_pkg.sv
rtl/sdp_ram.sv
icache/icache_decode.sv
icache/icache_lookup.sv
icache/icache_refill.sv
icache/icache_result.sv
rtl/icache_top.sv
test/icache_asserts.sv
test/icache_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f icache.f --top-module icache_tb -o icache_sim

./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
else
    exit 1
fi
